// ==== source/mio_pkg.sv ====
//##################################################
// mio link package
// widths, queue sizing and shared types for the transmitter
//##################################################
package mio_pkg;

   //##################################################
   // link widths
   //##################################################
   localparam int mio_w         = 16;                      // pins per DDR phase
   localparam int beat_w        = 2 * mio_w;               // two IO words per beat
   localparam int beats_per_txn = 2;                       // beats in one transaction
   localparam int txn_w         = beat_w * beats_per_txn;  // core transaction

   //##################################################
   // queue sizing
   //##################################################
   localparam int fifo_depth = 4;                          // transactions held
   localparam int fifo_aw    = 2;                          // log2 of depth

   //##################################################
   // vector types
   //##################################################

   // one DDR half cycle on the pins
   typedef logic [mio_w-1:0]   io_word_t;

   // lower word goes out first, on the high phase
   typedef logic [beat_w-1:0]  beat_t;

   // lower beat goes out first
   typedef logic [txn_w-1:0]   txn_t;

   // queue address
   typedef logic [fifo_aw-1:0] fifo_ptr_t;

   // serializer fsm
   typedef enum logic [1:0] {
      idle  = 2'd0,                                        // nothing latched
      beat0 = 2'd1,                                        // lower beat on io
      beat1 = 2'd2                                         // upper beat on io
   } ser_state_t;

endpackage

// ==== source/oh_rsync.sv ====
//##################################################
// reset synchronizer
// asserts at once, releases after two clock edges
//##################################################
`timescale 1ns/1ps

module oh_rsync (
   input  logic clk,            // destination clock
   input  logic nrst_in,        // async reset, active low
   output logic nrst_out        // synchronized reset, active low
);

   logic [1:0] sync_q;          // two flop chain

   //##################################################
   // chain fills with ones after release
   //##################################################
   always_ff @(posedge clk or negedge nrst_in) begin
      if (!nrst_in) begin
         sync_q <= 2'b00;                   // clear at once
      end
      else begin
         sync_q <= {sync_q[0], 1'b1};       // shift in ones
      end
   end

   // last stage drives the domain
   assign nrst_out = sync_q[1];

endmodule

// ==== source/oh_oddr.sv ====
//##################################################
// DDR output register
// two words per cycle, first on high phase, second on low
//##################################################
`timescale 1ns/1ps

module oh_oddr
   import mio_pkg::*;
(
   input  logic     clk,        // output clock
   input  logic     ce,         // capture enable
   input  io_word_t din1,       // word for high phase
   input  io_word_t din2,       // word for low phase
   output io_word_t out         // pin group
);

   io_word_t q1;                // rising edge copy of din1
   io_word_t q2;                // rising edge copy of din2
   io_word_t q2_sh;             // q2 moved to falling edge

   //##################################################
   // rising edge capture
   //##################################################
   always_ff @(posedge clk) begin
      if (ce) begin
         q1 <= din1;
         q2 <= din2;
      end
   end

   // second word moves over half a cycle later
   always_ff @(negedge clk) begin
      q2_sh <= q2;              // stable for the whole low phase
   end

   //##################################################
   // phase mux
   //##################################################

   // clk high shows the first word, clk low the falling copy
   assign out = clk ? q1 : q2_sh;

endmodule

// ==== source/mtx_io.sv ====
//##################################################
// transmit IO stage
// SDR access line and DDR data pins, held during tx_wait
//##################################################
`timescale 1ns/1ps

module mtx_io
   import mio_pkg::*;
(
   input  logic     clk,        // link clock
   input  logic     io_nreset,  // async reset, active low
   input  logic     io_access,  // beat valid
   input  beat_t    io_packet,  // beat to send
   input  logic     tx_wait,    // pushback from far end
   output logic     tx_access,  // access pin
   output io_word_t tx_packet   // data pins
);

   logic     io_nreset_sync;    // reset local to this stage
   logic     oddr_ce;           // DDR capture enable
   io_word_t word_lo;           // high phase word
   io_word_t word_hi;           // low phase word

   //##################################################
   // reset
   //##################################################
   oh_rsync u_rsync (
      .clk      (clk),
      .nrst_in  (io_nreset),
      .nrst_out (io_nreset_sync)
   );

   //##################################################
   // access line, single rate
   //##################################################
   always_ff @(posedge clk or negedge io_nreset_sync) begin
      if (!io_nreset_sync) begin
         tx_access <= 1'b0;
      end
      else if (!tx_wait) begin
         tx_access <= io_access;            // frozen while far end waits
      end
   end

   //##################################################
   // data, double rate
   //##################################################

   // zeros are loaded every edge while in reset
   assign oddr_ce = ~io_nreset_sync | (io_access & ~tx_wait);
   assign word_lo = io_nreset_sync ? io_packet[mio_w-1:0]      : '0;
   assign word_hi = io_nreset_sync ? io_packet[beat_w-1:mio_w] : '0;

   oh_oddr u_data_oddr (
      .clk  (clk),
      .ce   (oddr_ce),
      .din1 (word_lo),          // lower word first
      .din2 (word_hi),
      .out  (tx_packet)
   );

endmodule

// ==== source/mtx_fifo.sv ====
//##################################################
// transaction queue
// register array fifo with full and empty flags
//##################################################
`timescale 1ns/1ps

module mtx_fifo
   import mio_pkg::*;
(
   input  logic clk,            // core clock
   input  logic io_nreset,      // async reset, active low
   input  logic push,           // write strobe
   input  txn_t din,            // write data
   input  logic pop,            // take head entry
   output txn_t dout,           // head entry
   output logic full,           // no room left
   output logic empty           // nothing queued
);

   txn_t           mem [fifo_depth];   // storage, no reset
   fifo_ptr_t      wr_ptr;             // next slot to write
   fifo_ptr_t      rd_ptr;             // head slot
   logic [fifo_aw:0] count;            // entries held
   logic           do_push;            // accepted write
   logic           do_pop;             // accepted read

   //##################################################
   // qualified strobes
   //##################################################
   assign do_push = push & ~full;      // dropped when full
   assign do_pop  = pop & ~empty;      // ignored when empty

   //##################################################
   // storage
   //##################################################
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= din;
      end
   end

   //##################################################
   // pointers and count
   //##################################################
   always_ff @(posedge clk or negedge io_nreset) begin
      if (!io_nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // both or neither
         endcase
      end
   end

   //##################################################
   // outputs
   //##################################################
   assign dout  = mem[rd_ptr];         // head always visible
   assign full  = (count == (fifo_aw + 1)'(fifo_depth));
   assign empty = (count == '0);

endmodule

// ==== source/mtx_serializer.sv ====
//##################################################
// beat serializer
// cuts each transaction into two beats, stalls on tx_wait
//##################################################
`timescale 1ns/1ps

module mtx_serializer
   import mio_pkg::*;
(
   input  logic  clk,           // link clock
   input  logic  io_nreset,     // async reset, active low
   input  txn_t  fifo_dout,     // queue head
   input  logic  fifo_empty,    // queue has nothing
   output logic  fifo_pop,      // take the head
   input  logic  tx_wait,       // pushback from far end
   output logic  io_access,     // beat valid
   output beat_t io_packet      // beat to send
);

   ser_state_t state;           // current beat
   ser_state_t state_nxt;
   txn_t       txn_q;           // latched transaction, no reset
   logic       beat_sent;       // beat leaves this edge

   //##################################################
   // handshake terms
   //##################################################
   assign beat_sent = io_access & ~tx_wait;

   // pop from idle, or right after the upper beat leaves
   always_comb begin
      fifo_pop = 1'b0;
      if (!fifo_empty) begin
         if (state == idle) begin
            fifo_pop = 1'b1;
         end
         else if (state == beat1 && beat_sent) begin
            fifo_pop = 1'b1;             // keeps beats back to back
         end
      end
   end

   //##################################################
   // next state
   //##################################################
   always_comb begin
      state_nxt = state;
      case (state)
         idle: begin
            if (fifo_pop) begin
               state_nxt = beat0;
            end
         end
         beat0: begin
            if (beat_sent) begin
               state_nxt = beat1;        // lower beat gone
            end
         end
         beat1: begin
            if (beat_sent) begin
               state_nxt = fifo_pop ? beat0 : idle;
            end
         end
         default: state_nxt = idle;
      endcase
   end

   //##################################################
   // state and payload registers
   //##################################################
   always_ff @(posedge clk or negedge io_nreset) begin
      if (!io_nreset) begin
         state <= idle;
      end
      else begin
         state <= state_nxt;
      end
   end

   // head is latched on every pop
   always_ff @(posedge clk) begin
      if (fifo_pop) begin
         txn_q <= fifo_dout;
      end
   end

   //##################################################
   // beat select
   //##################################################
   assign io_access = (state != idle);
   assign io_packet = (state == beat1) ? txn_q[txn_w-1:beat_w]   // upper beat
                                       : txn_q[beat_w-1:0];      // lower beat

endmodule

// ==== source/mtx.sv ====
//##################################################
// link transmitter top
// queue, serializer and IO stage
//##################################################
`timescale 1ns/1ps

module mtx
   import mio_pkg::*;
(
   input  logic     clk,          // link clock
   input  logic     io_nreset,    // async reset, active low
   input  logic     core_access,  // transaction strobe
   input  txn_t     core_packet,  // transaction
   output logic     core_wait,    // queue full
   input  logic     tx_wait,      // pushback from far end
   output logic     tx_access,    // access pin
   output io_word_t tx_packet     // data pins
);

   txn_t  fifo_dout;              // queue head
   logic  fifo_empty;
   logic  fifo_pop;
   logic  io_access;              // beat valid
   beat_t io_packet;              // beat to send

   //##################################################
   // core side queue
   //##################################################
   mtx_fifo u_fifo (
      .clk       (clk),
      .io_nreset (io_nreset),
      .push      (core_access),
      .din       (core_packet),
      .pop       (fifo_pop),
      .dout      (fifo_dout),
      .full      (core_wait),     // full flag is the core pushback
      .empty     (fifo_empty)
   );

   //##################################################
   // transaction to beats
   //##################################################
   mtx_serializer u_ser (
      .clk        (clk),
      .io_nreset  (io_nreset),
      .fifo_dout  (fifo_dout),
      .fifo_empty (fifo_empty),
      .fifo_pop   (fifo_pop),
      .tx_wait    (tx_wait),
      .io_access  (io_access),
      .io_packet  (io_packet)
   );

   //##################################################
   // pins
   //##################################################
   mtx_io u_io (
      .clk       (clk),
      .io_nreset (io_nreset),
      .io_access (io_access),
      .io_packet (io_packet),
      .tx_wait   (tx_wait),
      .tx_access (tx_access),
      .tx_packet (tx_packet)
   );

endmodule

// ==== dv/mtx_tb.sv ====
//##################################################
// mtx testbench
// LFSR traffic, DDR receiver model and scoreboard
//##################################################
`timescale 1ns/1ps

module mtx_tb
   import mio_pkg::*;
();

   logic     clk = 1'b0;
   logic     io_nreset;
   logic     core_access;
   txn_t     core_packet;
   logic     core_wait;
   logic     tx_wait = 1'b0;
   logic     tx_access;
   io_word_t tx_packet;

   logic [31:0] lfsr      = 32'h835266e0;   // transaction bits
   logic [31:0] wait_lfsr = 32'h835266e0;   // tx_wait bits
   logic        rand_wait = 1'b0;           // random pushback on
   logic        hold_wait = 1'b0;           // tx_wait level otherwise

   txn_t     exp_q [$];                     // accepted but not yet seen on pins
   beat_t    beat_lo;                       // first beat of current txn
   logic     beat_idx      = 1'b0;
   int       cyc           = 0;
   int       prev_beat_cyc = 0;
   int       stream_beats  = 0;
   logic     check_stream  = 1'b0;          // beats must be back to back
   logic     checks_on     = 1'b0;          // set after reset release
   logic     prev_acc;                      // pin values one cycle back
   io_word_t prev_lo;
   io_word_t prev_hi;
   int       errors   = 0;
   int       err_mark = 0;
   int       passed   = 0;
   int       failed   = 0;

   always #20 clk = ~clk;                   // 40 ns period

   mtx dut0 (
      .clk         (clk),
      .io_nreset   (io_nreset),
      .core_access (core_access),
      .core_packet (core_packet),
      .core_wait   (core_wait),
      .tx_wait     (tx_wait),
      .tx_access   (tx_access),
      .tx_packet   (tx_packet)
   );

   //##################################################
   // random source
   //##################################################
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'h80200003;               // galois taps 32 22 2 1
      end
      return n;
   endfunction

   task automatic rand_txn(output txn_t t);
      t = '0;
      for (int i = 0; i < txn_w; i++) begin
         t    = {lfsr[0], t[txn_w-1:1]};      // one step per bit
         lfsr = lfsr_step(lfsr);
      end
   endtask

   // far end pushback
   always @(posedge clk) begin
      if (rand_wait) begin
         tx_wait   <= wait_lfsr[0];
         wait_lfsr  = lfsr_step(wait_lfsr);
      end
      else begin
         tx_wait <= hold_wait;
      end
   end

   // scoreboard fill with values as the DUT samples them
   always @(posedge clk) begin
      if (io_nreset && core_access && !core_wait) begin
         exp_q.push_back(core_packet);
      end
   end

   //##################################################
   // DDR receiver model
   //##################################################
   always @(posedge clk) begin
      logic  wait_q;
      logic  is_beat;
      beat_t beat;
      txn_t  got;
      txn_t  exp;
      wait_q = tx_wait;                      // level the DUT used at this edge
      cyc    = cyc + 1;
      #10;
      if (checks_on && wait_q) begin
         assert (tx_access == prev_acc && tx_packet == prev_lo) else begin
            $display("Fail %0t: pins moved in high phase during tx_wait", $time);
            errors++;
         end
      end
      is_beat          = checks_on && tx_access && !wait_q;
      beat[mio_w-1:0]  = tx_packet;          // lower word
      prev_acc         = tx_access;
      prev_lo          = tx_packet;
      #20;
      if (checks_on && wait_q) begin
         assert (tx_packet == prev_hi) else begin
            $display("Fail %0t: pins moved in low phase during tx_wait", $time);
            errors++;
         end
      end
      beat[beat_w-1:mio_w] = tx_packet;      // upper word
      prev_hi              = tx_packet;
      if (is_beat) begin
         if (check_stream && stream_beats > 0) begin
            assert (cyc == prev_beat_cyc + 1) else begin
               $display("Fail %0t: %0d cycle gap between beats", $time,
                        cyc - prev_beat_cyc);
               errors++;
            end
         end
         stream_beats++;
         prev_beat_cyc = cyc;
         if (!beat_idx) begin
            beat_lo  = beat;
            beat_idx = 1'b1;
         end
         else begin
            beat_idx = 1'b0;
            got      = {beat, beat_lo};      // lower beat came first
            assert (exp_q.size() != 0) else begin
               $display("transaction %h arrived with nothing outstanding", got);
               errors++;
            end
            if (exp_q.size() != 0) begin
               exp = exp_q.pop_front();
               assert (got == exp) else begin
                  $display("Fail %0t: got %h expected %h", $time, got, exp);
                  errors++;
               end
            end
         end
      end
   end

   //##################################################
   // helpers
   //##################################################
   task automatic report_timeout(input string what);
      $display("timeout at %0t while waiting for %s", $time, what);
      errors++;
   endtask

   task automatic push_txn(input txn_t t);
      int n;
      n = 0;
      @(posedge clk);
      while (core_wait && n < 1000) begin   // never strobe into a full queue
         @(posedge clk);
         n++;
      end
      if (core_wait) begin
         report_timeout("core_wait to fall");
      end
      else begin
         core_access <= 1'b1;
         core_packet <= t;
         @(posedge clk);
         core_access <= 1'b0;
      end
   endtask

   task automatic wait_drain(input string what);
      int n;
      n = 0;
      @(posedge clk);                        // let the last strobe land
      while ((exp_q.size() != 0 || beat_idx) && n < 4000) begin
         @(posedge clk);
         n++;
      end
      if (exp_q.size() != 0 || beat_idx) begin
         report_timeout(what);
      end
   endtask

   task automatic check_idle();
      #10;
      assert (tx_access == 1'b0 && tx_packet == '0 && core_wait == 1'b0) else begin
         $display("Fail %0t: not idle, access %b packet %h core_wait %b", $time,
                  tx_access, tx_packet, core_wait);
         errors++;
      end
      #20;
      assert (tx_packet == '0) else begin
         $display("Fail %0t: low phase word %h in reset", $time, tx_packet);
         errors++;
      end
   endtask

   task automatic end_test(input string name);
      if (errors == err_mark) begin
         $display("test %s: ok", name);
         passed++;
      end
      else begin
         $display("test %s: failed with %0d errors", name, errors - err_mark);
         failed++;
      end
      err_mark = errors;
   endtask

   //##################################################
   // test sequence
   //##################################################
   initial begin
      txn_t t;
      io_nreset   = 1'b0;
      core_access = 1'b0;
      core_packet = '0;

      // 16 edges in reset then two more while the synchronizer fills
      for (int i = 0; i < 18; i++) begin
         @(posedge clk);
         if (i == 15) begin
            io_nreset <= 1'b1;
         end
         if (i >= 2) begin
            check_idle();
         end
      end
      checks_on = 1'b1;
      end_test("reset");

      check_stream = 1'b1;
      stream_beats = 0;
      rand_txn(t);
      push_txn(t);
      wait_drain("single transaction");
      assert (stream_beats == 2) else begin
         $display("Fail %0t: %0d beats for one transaction", $time, stream_beats);
         errors++;
      end
      check_stream = 1'b0;
      end_test("single");

      check_stream = 1'b1;
      stream_beats = 0;
      repeat (20) begin
         rand_txn(t);
         push_txn(t);
      end
      wait_drain("streamed transactions");
      assert (stream_beats == 40) else begin
         $display("Fail %0t: %0d beats for 20 transactions", $time, stream_beats);
         errors++;
      end
      check_stream = 1'b0;
      end_test("streaming");

      @(negedge clk) rand_wait = 1'b1;
      repeat (20) begin
         rand_txn(t);
         push_txn(t);
      end
      wait_drain("transactions under random tx_wait");
      @(negedge clk) rand_wait = 1'b0;
      end_test("backpressure");

      // one txn parks in the serializer and four fill the queue
      @(negedge clk) hold_wait = 1'b1;
      repeat (fifo_depth + 1) begin
         rand_txn(t);
         push_txn(t);
      end
      @(posedge clk);
      assert (core_wait && exp_q.size() == fifo_depth + 1) else begin
         $display("Fail %0t: core_wait %b with %0d outstanding", $time,
                  core_wait, exp_q.size());
         errors++;
      end
      @(negedge clk) hold_wait = 1'b0;
      wait_drain("queued transactions after tx_wait release");
      assert (!core_wait) else begin
         $display("Fail %0t: core_wait still high after drain", $time);
         errors++;
      end
      end_test("queue full");

      $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
      if (errors == 0) begin
         $display("=== PASS ===");
      end
      else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// ==== src.f ====
source/mio_pkg.sv
source/oh_rsync.sv
source/oh_oddr.sv
source/mtx_io.sv
source/mtx_fifo.sv
source/mtx_serializer.sv
source/mtx.sv
dv/mtx_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the transmitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module mtx_tb -f src.f -Mdir obj_dir
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "build failed with status $build_status"
   exit 1
fi

sim_output=$(./obj_dir/Vmtx_tb)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_output" | grep -qxF -- "=== PASS ==="; then
   exit 0
else
   exit 1
fi
